/* rtl/asm_defines.svh */
`ifndef ASM_DEFINES_SVH
`define ASM_DEFINES_SVH

// sizing of the outbound assembler datapath

// bits carried by one lane slice of the wide word
// and by one narrow output channel word
`define ASM_WIDTH 8

// lane slices packed side by side in one wide input word
// lane 0 sits in the low bits
`define ASM_NUM_IN 4

// narrow output channels fed by the round-robin distributor
`define ASM_NUM_OUT 4

// total width of the wide input word
`define ASM_WIDE_WIDTH (`ASM_NUM_IN * `ASM_WIDTH)

`endif

/* rtl/asm_data_pkg.sv */
`include "asm_defines.svh"

package asm_data_pkg;

   // one lane slice, also the word size of each output channel
   typedef logic [`ASM_WIDTH-1:0] lane_word_t;

   // index of an input lane
   // sized so the top lane number fits
   typedef logic [$clog2(`ASM_NUM_IN)-1:0] in_idx_t;

   // index of an output channel
   typedef logic [$clog2(`ASM_NUM_OUT)-1:0] out_idx_t;

   // highest index values, used as the reset value of the top settings
   localparam in_idx_t IN_IDX_MAX = in_idx_t'(`ASM_NUM_IN - 1);
   localparam out_idx_t OUT_IDX_MAX = out_idx_t'(`ASM_NUM_OUT - 1);

endpackage

/* rtl/asm_cfg_pkg.sv */
package asm_cfg_pkg;

   // width of a register write word
   localparam int CFG_WORD_W = 8;

   // reserved bits left over in the channel view
   localparam int CHAN_RSVD_W = CFG_WORD_W
                                - $bits(asm_data_pkg::in_idx_t)
                                - $bits(asm_data_pkg::out_idx_t);

   // register select
   typedef enum logic [0:0] {
      CFG_CHAN = 1'b0,
      CFG_CTRL = 1'b1
   } cfg_addr_e;

   // channel register view
   // in_top sits in the low bits, out_top right above it
   typedef struct packed {
      logic [CHAN_RSVD_W-1:0]  reserved;
      asm_data_pkg::out_idx_t  out_top;
      asm_data_pkg::in_idx_t   in_top;
   } cfg_chan_t;

   // control register view, calibration flag in bit 0
   typedef struct packed {
      logic [CFG_WORD_W-2:0] reserved;
      logic                  calibration_done;
   } cfg_ctrl_t;

   // one write word, read through whichever view the address picks
   typedef union packed {
      cfg_chan_t chan;
      cfg_ctrl_t ctrl;
   } cfg_word_u;

endpackage

/* rtl/asm_two_fifo.sv */
`timescale 1ns/1ps
`include "asm_defines.svh"

module asm_two_fifo #(
   parameter int width = `ASM_WIDTH
) (
   input  logic             clk,
   input  logic             reset_i,
   input  logic             v_i,
   input  logic [width-1:0] data_i,
   output logic             ready_param_o,
   output logic             v_o,
   output logic [width-1:0] data_o,
   input  logic             yumi_i
);

   // two storage slots for the payload
   logic [width-1:0] mem [1:0];

   // one-bit pointers toggle between the slots
   logic rd_ptr_r;
   logic wr_ptr_r;

   // pointers alone cannot tell full from empty
   logic full_r;
   logic empty;

   assign empty = (rd_ptr_r == wr_ptr_r) && !full_r;

   // not-full comes straight off a flop
   assign ready_param_o = !full_r;

   // head word is always the slot under the read pointer
   assign v_o    = !empty;
   assign data_o = mem[rd_ptr_r];

   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         rd_ptr_r <= 1'b0;
         wr_ptr_r <= 1'b0;
         full_r   <= 1'b0;
      end
      else
      begin
         if (v_i)
            wr_ptr_r <= ~wr_ptr_r;
         if (yumi_i)
            rd_ptr_r <= ~rd_ptr_r;
         // write alone fills when the next slot is the reader's
         // read alone always frees a slot and both together hold the level
         if (v_i && !yumi_i)
            full_r <= (~wr_ptr_r == rd_ptr_r);
         else if (yumi_i && !v_i)
            full_r <= 1'b0;
      end
   end

   // slot write
   always_ff @(posedge clk)
   begin
      if (v_i)
         mem[wr_ptr_r] <= data_i;
   end

   // the assembler must only enqueue when the fifo has room
   a_no_enq_full: assert property (@(posedge clk) disable iff (reset_i) v_i |-> !full_r)
      else $error("asm_two_fifo: enqueue while full");

   // the distributor must only take a word that is there
   a_no_deq_empty: assert property (@(posedge clk) disable iff (reset_i) yumi_i |-> !empty)
      else $error("asm_two_fifo: yumi while empty");

endmodule

/* rtl/asm_rr_fifo_to_fifo.sv */
`timescale 1ns/1ps
`include "asm_defines.svh"

module asm_rr_fifo_to_fifo #(
   parameter int width   = `ASM_WIDTH,
   parameter int num_in  = `ASM_NUM_IN,
   parameter int num_out = `ASM_NUM_OUT
) (
   input  logic                     clk,
   input  logic                     reset_i,
   input  asm_data_pkg::in_idx_t    in_top_channel_i,
   input  asm_data_pkg::out_idx_t   out_top_channel_i,
   input  logic [num_in-1:0]        valid_i,
   input  asm_data_pkg::lane_word_t data_i [num_in-1:0],
   output logic [num_in-1:0]        yumi_o,
   output logic [num_out-1:0]       valid_o,
   output asm_data_pkg::lane_word_t data_o [num_out-1:0],
   input  logic [num_out-1:0]       ready_i
);

   // word size and counts have to fit the shared lane and index types
   if (width != $bits(asm_data_pkg::lane_word_t))
   begin : g_bad_width
      $error("asm_rr_fifo_to_fifo: width does not match lane_word_t");
   end
   if (num_in > (1 << $bits(asm_data_pkg::in_idx_t)))
   begin : g_bad_num_in
      $error("asm_rr_fifo_to_fifo: num_in too large for in_idx_t");
   end
   if (num_out > (1 << $bits(asm_data_pkg::out_idx_t)))
   begin : g_bad_num_out
      $error("asm_rr_fifo_to_fifo: num_out too large for out_idx_t");
   end

   // lane currently being drained
   asm_data_pkg::in_idx_t in_ptr_r;
   // channel that gets the next word
   asm_data_pkg::out_idx_t out_ptr_r;

   // head of the selected lane fifo
   logic             head_v;
   logic [width-1:0] head_word;

   // one word moves this cycle
   logic xfer;

   assign head_v    = valid_i[in_ptr_r];
   assign head_word = data_i[in_ptr_r];

   // peek at the pointed channel's ready, valid_o never looks at it
   assign xfer = head_v && ready_i[out_ptr_r];

   // valid only on the pointed channel, yumi only on the pointed lane
   always_comb
   begin
      valid_o            = '0;
      valid_o[out_ptr_r] = head_v;
      yumi_o             = '0;
      yumi_o[in_ptr_r]   = xfer;
   end

   // head word goes out on every channel
   // only the one flagged by valid_o counts
   always_comb
   begin
      for (int k = 0; k < num_out; k++)
         data_o[k] = head_word;
   end

   // strict round robin on both sides
   // each pointer wraps after its top setting
   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         in_ptr_r  <= '0;
         out_ptr_r <= '0;
      end
      else if (xfer)
      begin
         if (in_ptr_r == in_top_channel_i)
            in_ptr_r <= '0;
         else
            in_ptr_r <= in_ptr_r + 1'b1;

         if (out_ptr_r == out_top_channel_i)
            out_ptr_r <= '0;
         else
            out_ptr_r <= out_ptr_r + 1'b1;
      end
   end

   // at most one channel offered a word at a time
   a_valid_onehot: assert property (@(posedge clk) disable iff (reset_i) $onehot0(valid_o))
      else $error("asm_rr_fifo_to_fifo: valid_o not one-hot");

   // never pop a lane fifo that has nothing in it
   a_yumi_valid: assert property (@(posedge clk) disable iff (reset_i)
                                  (yumi_o & ~valid_i) == '0)
      else $error("asm_rr_fifo_to_fifo: yumi on an empty lane");

endmodule

/* rtl/asm_assembler_out.sv */
`timescale 1ns/1ps
`include "asm_defines.svh"

module asm_assembler_out (
   input  logic                          clk,
   input  logic                          reset_i,
   input  logic                          calibration_done_i,
   input  logic                          valid_i,
   input  logic [`ASM_WIDE_WIDTH-1:0]    data_i,
   output logic                          ready_o,
   input  asm_data_pkg::in_idx_t         in_top_channel_i,
   input  asm_data_pkg::out_idx_t        out_top_channel_i,
   output logic [`ASM_NUM_OUT-1:0]       valid_o,
   output asm_data_pkg::lane_word_t      data_o [`ASM_NUM_OUT-1:0],
   input  logic [`ASM_NUM_OUT-1:0]       ready_i
);

   // lanes up to in_top take part, the rest are ignored
   logic [`ASM_NUM_IN-1:0] lane_active;

   // per-lane fifo handshakes
   logic [`ASM_NUM_IN-1:0]   fifo_not_full;
   logic [`ASM_NUM_IN-1:0]   fifo_enq;
   logic [`ASM_NUM_IN-1:0]   fifo_valid;
   logic [`ASM_NUM_IN-1:0]   fifo_yumi;
   asm_data_pkg::lane_word_t fifo_data [`ASM_NUM_IN-1:0];

   always_comb
   begin
      for (int i = 0; i < `ASM_NUM_IN; i++)
         lane_active[i] = (i <= int'(in_top_channel_i));
   end

   // accept only once calibrated and every active lane has a free slot
   // inactive lanes count as always having room
   assign ready_o = calibration_done_i && (&(fifo_not_full | ~lane_active));

   // an accepted word drops one slice into each active lane
   assign fifo_enq = {`ASM_NUM_IN{valid_i && ready_o}} & lane_active;

   // lane fifos let one wide word drain a slice at a time
   for (genvar i = 0; i < `ASM_NUM_IN; i++)
   begin : g_lane
      asm_two_fifo #(
         .width(`ASM_WIDTH)
      ) i_lane_fifo (
         .clk           (clk),
         .reset_i       (reset_i),
         .v_i           (fifo_enq[i]),
         .data_i        (data_i[`ASM_WIDTH*i +: `ASM_WIDTH]),
         .ready_param_o (fifo_not_full[i]),
         .v_o           (fifo_valid[i]),
         .data_o        (fifo_data[i]),
         .yumi_i        (fifo_yumi[i])
      );
   end

   // ordering across lanes and channels lives in the distributor
   asm_rr_fifo_to_fifo #(
      .width   (`ASM_WIDTH),
      .num_in  (`ASM_NUM_IN),
      .num_out (`ASM_NUM_OUT)
   ) i_rr_fifo_to_fifo (
      .clk               (clk),
      .reset_i           (reset_i),
      .in_top_channel_i  (in_top_channel_i),
      .out_top_channel_i (out_top_channel_i),
      .valid_i           (fifo_valid),
      .data_i            (fifo_data),
      .yumi_o            (fifo_yumi),
      .valid_o           (valid_o),
      .data_o            (data_o),
      .ready_i           (ready_i)
   );

endmodule

/* rtl/asm_cfg_regs.sv */
`timescale 1ns/1ps

module asm_cfg_regs (
   input  logic                    clk,
   input  logic                    reset_i,
   input  logic                    cfg_we_i,
   input  asm_cfg_pkg::cfg_addr_e  cfg_addr_i,
   input  asm_cfg_pkg::cfg_word_u  cfg_data_i,
   output logic                    calibration_done_o,
   output asm_data_pkg::in_idx_t   in_top_channel_o,
   output asm_data_pkg::out_idx_t  out_top_channel_o
);

   // per-register write strobes
   logic chan_we;
   logic ctrl_we;

   assign chan_we = cfg_we_i && (cfg_addr_i == asm_cfg_pkg::CFG_CHAN);
   assign ctrl_we = cfg_we_i && (cfg_addr_i == asm_cfg_pkg::CFG_CTRL);

   // settings land one cycle after the strobe
   // out of reset nothing is accepted and every lane and channel is in use
   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         calibration_done_o <= 1'b0;
         in_top_channel_o   <= asm_data_pkg::IN_IDX_MAX;
         out_top_channel_o  <= asm_data_pkg::OUT_IDX_MAX;
      end
      else
      begin
         // channel view of the word, both tops move together
         if (chan_we)
         begin
            in_top_channel_o  <= cfg_data_i.chan.in_top;
            out_top_channel_o <= cfg_data_i.chan.out_top;
         end
         // control view of the same word
         if (ctrl_we)
            calibration_done_o <= cfg_data_i.ctrl.calibration_done;
      end
   end

   // software keeps the unused bits of either view at zero
   a_chan_rsvd_zero: assert property (@(posedge clk) disable iff (reset_i)
                                      chan_we |-> (cfg_data_i.chan.reserved == '0))
      else $error("asm_cfg_regs: reserved channel bits written non-zero");

   a_ctrl_rsvd_zero: assert property (@(posedge clk) disable iff (reset_i)
                                      ctrl_we |-> (cfg_data_i.ctrl.reserved == '0))
      else $error("asm_cfg_regs: reserved control bits written non-zero");

endmodule

/* rtl/asm_top.sv */
`timescale 1ns/1ps
`include "asm_defines.svh"

module asm_top (
   input  logic                      clk,
   input  logic                      reset_i,
   input  logic                      cfg_we_i,
   input  asm_cfg_pkg::cfg_addr_e    cfg_addr_i,
   input  asm_cfg_pkg::cfg_word_u    cfg_data_i,
   input  logic                      valid_i,
   input  logic [`ASM_WIDE_WIDTH-1:0] data_i,
   output logic                      ready_o,
   output logic [`ASM_NUM_OUT-1:0]   valid_o,
   output asm_data_pkg::lane_word_t  data_o [`ASM_NUM_OUT-1:0],
   input  logic [`ASM_NUM_OUT-1:0]   ready_i
);

   // settings from the register block, plain levels
   logic                   calibration_done;
   asm_data_pkg::in_idx_t  in_top_channel;
   asm_data_pkg::out_idx_t out_top_channel;

   asm_cfg_regs i_cfg_regs (
      .clk                (clk),
      .reset_i            (reset_i),
      .cfg_we_i           (cfg_we_i),
      .cfg_addr_i         (cfg_addr_i),
      .cfg_data_i         (cfg_data_i),
      .calibration_done_o (calibration_done),
      .in_top_channel_o   (in_top_channel),
      .out_top_channel_o  (out_top_channel)
   );

   asm_assembler_out i_assembler_out (
      .clk                (clk),
      .reset_i            (reset_i),
      .calibration_done_i (calibration_done),
      .valid_i            (valid_i),
      .data_i             (data_i),
      .ready_o            (ready_o),
      .in_top_channel_i   (in_top_channel),
      .out_top_channel_i  (out_top_channel),
      .valid_o            (valid_o),
      .data_o             (data_o),
      .ready_i            (ready_i)
   );

endmodule

/* sim/tb_asm_checks.svh */
`ifndef TB_ASM_CHECKS_SVH
`define TB_ASM_CHECKS_SVH

// expected lane words in output order, each paired with its channel
asm_data_pkg::lane_word_t exp_data_q [$];
asm_data_pkg::out_idx_t   exp_chan_q [$];

// model copies of the settings and of the output pointer
asm_data_pkg::in_idx_t  model_in_top;
asm_data_pkg::out_idx_t model_out_top;
asm_data_pkg::out_idx_t model_out_ptr;

int    err_cnt;
int    check_cnt;
string test_name;

// lane n sits in bits n*width upward
function automatic asm_data_pkg::lane_word_t lane_slice(
   logic [`ASM_WIDE_WIDTH-1:0] word,
   int                         lane
);
   return word[lane*`ASM_WIDTH +: `ASM_WIDTH];
endfunction

// channel order is 0 .. top, then back to 0
function automatic asm_data_pkg::out_idx_t next_out_ptr(
   asm_data_pkg::out_idx_t ptr,
   asm_data_pkg::out_idx_t top
);
   if (ptr == top)
      return '0;
   return asm_data_pkg::out_idx_t'(ptr + 1);
endfunction

// every active lane of an accepted word leaves in lane order
task automatic push_expected(logic [`ASM_WIDE_WIDTH-1:0] word);
   for (int lane = 0; lane <= int'(model_in_top); lane++)
   begin
      exp_data_q.push_back(lane_slice(word, lane));
      exp_chan_q.push_back(model_out_ptr);
      model_out_ptr = next_out_ptr(model_out_ptr, model_out_top);
   end
endtask

task automatic check_chan(string what, asm_data_pkg::out_idx_t exp, asm_data_pkg::out_idx_t act);
   check_cnt++;
   if (exp !== act)
   begin
      $display("ERROR %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      err_cnt++;
   end
endtask

task automatic check_data(string what, asm_data_pkg::lane_word_t exp,
                          asm_data_pkg::lane_word_t act);
   check_cnt++;
   if (exp !== act)
   begin
      $display("ERROR %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      err_cnt++;
   end
endtask

task automatic check_flag(string what, logic exp, logic act);
   check_cnt++;
   if (exp !== act)
   begin
      $display("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act);
      err_cnt++;
   end
endtask

`endif

/* sim/tb_asm_top.sv */
`timescale 1ns/1ps
`include "asm_defines.svh"

module tb_asm_top;

   // word counts per test set the timeout
   localparam int N_STREAM    = 20;
   localparam int N_NARROW    = 12;
   localparam int N_RAND      = 24;
   localparam int N_HOLD      = 6;
   localparam int N_RESUME    = 4;
   localparam int TOTAL_WORDS = N_STREAM*4 + N_NARROW*2 + N_RAND*4 + N_HOLD*4 + N_RESUME*4;
   localparam int TIMEOUT_CYC = 4*TOTAL_WORDS + 200;

   // ready_i drive modes
   localparam int RDY_ALL  = 0;
   localparam int RDY_RAND = 1;
   localparam int RDY_HOLD = 2;

   logic                       clk;
   logic                       reset_i;
   logic                       cfg_we_i;
   asm_cfg_pkg::cfg_addr_e     cfg_addr_i;
   asm_cfg_pkg::cfg_word_u     cfg_data_i;
   logic                       valid_i;
   logic [`ASM_WIDE_WIDTH-1:0] data_i;
   logic                       ready_o;
   logic [`ASM_NUM_OUT-1:0]    valid_o;
   asm_data_pkg::lane_word_t   data_o [`ASM_NUM_OUT-1:0];
   logic [`ASM_NUM_OUT-1:0]    ready_i;

   integer seed = 32'h26ff;
   int     ready_mode;
   int     cycle_cnt;
   int     tests_run;
   int     tests_failed;
   int     test_err_start;

   // word offered on a channel but not taken at the last edge
   logic                     hold_v;
   asm_data_pkg::out_idx_t   hold_chan;
   asm_data_pkg::lane_word_t hold_data;

`include "tb_asm_checks.svh"

   asm_top i_asm_top (
      .clk        (clk),
      .reset_i    (reset_i),
      .cfg_we_i   (cfg_we_i),
      .cfg_addr_i (cfg_addr_i),
      .cfg_data_i (cfg_data_i),
      .valid_i    (valid_i),
      .data_i     (data_i),
      .ready_o    (ready_o),
      .valid_o    (valid_o),
      .data_o     (data_o),
      .ready_i    (ready_i)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // advance one falling edge and redrive ready_i for the current mode
   task automatic step();
      logic [31:0] rnd;
      @(negedge clk);
      case (ready_mode)
         RDY_RAND:
         begin
            rnd     = $random(seed);
            ready_i = rnd[`ASM_NUM_OUT-1:0];
         end
         RDY_HOLD: ready_i = '0;
         default:  ready_i = '1;
      endcase
   endtask

   task automatic write_cfg(asm_cfg_pkg::cfg_addr_e addr, asm_cfg_pkg::cfg_word_u word);
      cfg_we_i   = 1'b1;
      cfg_addr_i = addr;
      cfg_data_i = word;
      step();
      cfg_we_i = 1'b0;
      step();
   endtask

   task automatic write_chan(asm_data_pkg::in_idx_t in_top, asm_data_pkg::out_idx_t out_top);
      asm_cfg_pkg::cfg_word_u word;
      word             = '0;
      word.chan.in_top  = in_top;
      word.chan.out_top = out_top;
      write_cfg(asm_cfg_pkg::CFG_CHAN, word);
      model_in_top  = in_top;
      model_out_top = out_top;
   endtask

   task automatic write_ctrl(logic cal);
      asm_cfg_pkg::cfg_word_u word;
      word                       = '0;
      word.ctrl.calibration_done = cal;
      write_cfg(asm_cfg_pkg::CFG_CTRL, word);
   endtask

   // ready_o depends only on flops, so the value seen here holds through the next rising edge
   task automatic send_word(logic [`ASM_WIDE_WIDTH-1:0] word);
      logic got;
      valid_i = 1'b1;
      data_i  = word;
      got     = ready_o;
      while (!got)
      begin
         step();
         got = ready_o;
      end
      step();
   endtask

   task automatic send_stream(int n);
      for (int i = 0; i < n; i++)
         send_word($random(seed));
      valid_i = 1'b0;
   endtask

   task automatic wait_drain();
      while (exp_data_q.size() != 0)
         step();
      step();
   endtask

   task automatic start_test(string name);
      test_name      = name;
      test_err_start = err_cnt;
   endtask

   task automatic end_test();
      if (exp_data_q.size() != 0)
      begin
         $display("%s: %0d expected words never left the DUT", test_name, exp_data_q.size());
         err_cnt++;
      end
      tests_run++;
      if (err_cnt != test_err_start)
      begin
         tests_failed++;
         $display("test %s: FAIL, %0d errors", test_name, err_cnt - test_err_start);
      end
      else
         $display("test %s: ok", test_name);
   endtask

   // reference model records every accepted wide word
   always @(posedge clk)
   begin
      if (!reset_i && valid_i && ready_o)
         push_expected(data_i);
   end

   // output compare sees at most one transfer per edge
   always @(posedge clk)
   begin : compare
      logic [`ASM_NUM_OUT-1:0]  hit;
      asm_data_pkg::out_idx_t   act_chan;
      asm_data_pkg::out_idx_t   exp_chan;
      asm_data_pkg::lane_word_t exp_data;
      if (!reset_i)
      begin
         hit = valid_o & ready_i;
         if (!$onehot0(valid_o))
         begin
            $display("%s: valid_o has more than one bit set (%b)", test_name, valid_o);
            err_cnt++;
         end
         // a word that was not taken must still be offered unchanged
         if (hold_v)
         begin
            check_flag("held valid_o", 1'b1, valid_o[hold_chan]);
            check_data("held data_o", hold_data, data_o[hold_chan]);
         end
         if (hit != '0)
         begin
            act_chan = '0;
            for (int k = 0; k < `ASM_NUM_OUT; k++)
               if (hit[k])
                  act_chan = asm_data_pkg::out_idx_t'(k);
            if (exp_data_q.size() == 0)
            begin
               $display("%s: output word %0h on channel %0d with nothing expected",
                        test_name, data_o[act_chan], act_chan);
               err_cnt++;
            end
            else
            begin
               exp_chan = exp_chan_q.pop_front();
               exp_data = exp_data_q.pop_front();
               check_chan("channel", exp_chan, act_chan);
               check_data("data", exp_data, data_o[act_chan]);
            end
         end
         hold_v = (valid_o != '0) && (hit == '0);
         for (int k = 0; k < `ASM_NUM_OUT; k++)
            if (valid_o[k])
               hold_chan = asm_data_pkg::out_idx_t'(k);
         hold_data = data_o[hold_chan];
      end
   end

   // watchdog
   initial
   begin
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYC)
      begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Regression failed");
      $finish;
   end

   initial
   begin : stimulus
      logic [`ASM_WIDE_WIDTH-1:0] word;
      reset_i       = 1'b1;
      cfg_we_i      = 1'b0;
      cfg_addr_i    = asm_cfg_pkg::CFG_CHAN;
      cfg_data_i    = '0;
      valid_i       = 1'b0;
      data_i        = '0;
      ready_i       = '1;
      ready_mode    = RDY_ALL;
      hold_v        = 1'b0;
      hold_chan     = '0;
      hold_data     = '0;
      model_in_top  = asm_data_pkg::IN_IDX_MAX;
      model_out_top = asm_data_pkg::OUT_IDX_MAX;
      model_out_ptr = '0;
      test_name     = "reset";
      repeat (2) @(posedge clk);
      step();
      reset_i = 1'b0;
      step();

      // nothing moves until calibration is flagged
      start_test("no_calibration");
      valid_i = 1'b1;
      data_i  = $random(seed);
      repeat (10)
      begin
         check_flag("ready_o", 1'b0, ready_o);
         check_flag("valid_o", 1'b0, |valid_o);
         step();
      end
      valid_i = 1'b0;
      write_ctrl(1'b1);
      end_test();

      start_test("full_stream");
      write_chan(2'd3, 2'd3);
      send_stream(N_STREAM);
      wait_drain();
      end_test();

      // two lanes over three channels
      start_test("narrow_config");
      write_chan(2'd1, 2'd2);
      send_stream(N_NARROW);
      wait_drain();
      end_test();

      start_test("random_ready");
      write_chan(2'd3, 2'd3);
      ready_mode = RDY_RAND;
      send_stream(N_RAND);
      wait_drain();
      ready_mode = RDY_ALL;
      step();
      end_test();

      // two words fill every lane fifo and the third must wait
      start_test("backpressure");
      ready_mode = RDY_HOLD;
      step();
      send_word($random(seed));
      send_word($random(seed));
      word    = $random(seed);
      valid_i = 1'b1;
      data_i  = word;
      repeat (28)
      begin
         check_flag("ready_o while full", 1'b0, ready_o);
         step();
      end
      ready_mode = RDY_ALL;
      send_word(word);
      send_stream(N_HOLD - 3);
      wait_drain();
      end_test();

      start_test("calibration_toggle");
      write_ctrl(1'b0);
      valid_i = 1'b1;
      data_i  = $random(seed);
      repeat (8)
      begin
         check_flag("ready_o uncalibrated", 1'b0, ready_o);
         step();
      end
      valid_i = 1'b0;
      write_ctrl(1'b1);
      send_stream(N_RESUME);
      wait_drain();
      end_test();

      if (exp_data_q.size() != 0)
      begin
         $display("%0d expected words still queued at the end", exp_data_q.size());
         err_cnt++;
      end
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, check_cnt, err_cnt);
      if (err_cnt == 0 && tests_failed == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

/* vlog.f */
+incdir+rtl
+incdir+sim
rtl/asm_data_pkg.sv
rtl/asm_cfg_pkg.sv
rtl/asm_two_fifo.sv
rtl/asm_rr_fifo_to_fifo.sv
rtl/asm_assembler_out.sv
rtl/asm_cfg_regs.sv
rtl/asm_top.sv
sim/tb_asm_top.sv

/* Bender.yml */
package:
  name: asm_assembler_out

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/asm_data_pkg.sv
      - rtl/asm_cfg_pkg.sv
      - rtl/asm_two_fifo.sv
      - rtl/asm_rr_fifo_to_fifo.sv
      - rtl/asm_assembler_out.sv
      - rtl/asm_cfg_regs.sv
      - rtl/asm_top.sv
  - target: test
    include_dirs:
      - rtl
      - sim
    files:
      - sim/tb_asm_top.sv
